// ==== design/cdb_if.sv ====
/*
 * Common Data Bus
 * One lane per execution result, broadcast to the reorder buffer
 */
`timescale 1ns/1ps
`default_nettype none

interface cdb_if import core_cfg_pkg::*, core_types_pkg::*; ();

    // A lane with en high carries the result of the tagged instruction
    logic  en       [0:CDB_DEPTH-1];
    // Branch outcome, redirect set when the target differs from the fall-through
    logic  redirect [0:CDB_DEPTH-1];
    data_t data     [0:CDB_DEPTH-1];
    addr_t addr     [0:CDB_DEPTH-1];
    tag_t  tag      [0:CDB_DEPTH-1];

    // Producer side, the execution units
    modport src (
        output en, redirect, data, addr, tag
    );

    // Consumer side, the reorder buffer
    modport snk (
        input  en, redirect, data, addr, tag
    );

endinterface

`default_nettype wire

// ==== design/core_cfg_pkg.sv ====
/*
 * Core configuration
 * Sizes of the reorder buffer, CDB, register file and datapath
 */
`default_nettype none

package core_cfg_pkg;

    // Reorder buffer entries and the width of an entry index
    localparam int ROB_DEPTH  = 8;
    localparam int TAG_WIDTH  = 3;

    // Number of result lanes on the Common Data Bus
    localparam int CDB_DEPTH  = 2;

    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 32;

    // Architectural register file
    localparam int REG_COUNT  = 32;
    localparam int REG_WIDTH  = 5;
    localparam int SRC_COUNT  = 2;

endpackage

`default_nettype wire

// ==== design/core_types_pkg.sv ====
/*
 * Core types
 * Vector types of the datapath and the ROB operation kind
 */
`default_nettype none

package core_types_pkg;

    import core_cfg_pkg::*;

    // Register value or execution result
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Instruction address or branch target
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Architectural register index
    typedef logic [REG_WIDTH-1:0]  reg_t;

    // ROB entry index, which is also the tag an instruction carries
    typedef logic [TAG_WIDTH-1:0]  tag_t;

    // Head and tail pointers carry one extra bit that flips on every wrap
    // Equal index with a different wrap bit means the buffer is full
    typedef logic [TAG_WIDTH:0]    tagp_t;

    // What the retire logic has to do with an entry
    // Integer ops only write back, branches may redirect
    // Loads and stores also notify the load/store unit
    typedef enum logic [1:0] {
        ROB_OP_INT = 2'b00,
        ROB_OP_BR  = 2'b01,
        ROB_OP_LD  = 2'b10,
        ROB_OP_ST  = 2'b11
    } rob_op_t;

endpackage

`default_nettype wire

// ==== design/register_map.sv ====
/*
 * Register map
 * Committed value, producing ROB tag and ready bit per architectural register
 */
`timescale 1ns/1ps
`default_nettype none

module register_map import core_cfg_pkg::*, core_types_pkg::*; (
    input  wire logic clk,
    input  wire logic n_rst,

    regmap_if.map     regmap
);

    data_t                map_data [0:REG_COUNT-1];
    tag_t                 map_tag  [0:REG_COUNT-1];
    logic [REG_COUNT-1:0] map_rdy;
    logic                 rename_en;
    logic                 retire_en;
    logic                 retire_rdy;

    // Register 0 is hardwired to zero, so it is never renamed or written
    assign rename_en = regmap.rename_wr_en && (regmap.rename_rdest != '0);
    assign retire_en = regmap.retire_wr_en && (regmap.retire_rdest != '0);

    // Only the youngest producer of a register makes it ready again
    // An older retire leaves the register waiting on the newer tag
    // A rename of the same register in this cycle also keeps it waiting
    assign retire_rdy = retire_en &&
                        (map_tag[regmap.retire_rdest] == regmap.retire_tag) &&
                        !(rename_en && (regmap.rename_rdest == regmap.retire_rdest));

    // Lookups see the state from the last edge
    always_comb begin
        for (int i = 0; i < SRC_COUNT; i++) begin
            regmap.lookup_rdy[i]  = map_rdy[regmap.lookup_rsrc[i]];
            regmap.lookup_tag[i]  = map_tag[regmap.lookup_rsrc[i]];
            regmap.lookup_data[i] = map_data[regmap.lookup_rsrc[i]];
        end
    end

    // Committed data, every register starts at zero
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                map_data[i] <= '0;
            end
        end else if (retire_en) begin
            map_data[regmap.retire_rdest] <= regmap.retire_data;
        end
    end

    // Producer tag of the latest rename
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                map_tag[i] <= '0;
            end
        end else if (rename_en) begin
            map_tag[regmap.rename_rdest] <= regmap.rename_tag;
        end
    end

    // Ready bits
    // A redirect throws away all speculative renames, and the data kept
    // here is exactly the committed state, so every register is ready again
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            map_rdy <= '1;
        end else if (regmap.redirect) begin
            map_rdy <= '1;
        end else begin
            if (retire_rdy) begin
                map_rdy[regmap.retire_rdest] <= 1'b1;
            end
            if (rename_en) begin
                map_rdy[regmap.rename_rdest] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/regmap_if.sv ====
/*
 * Reorder buffer to register map link
 * Carries renames at dispatch, writes at retire and source lookups
 */
`timescale 1ns/1ps
`default_nettype none

interface regmap_if import core_cfg_pkg::*, core_types_pkg::*; ();

    // Rename of the destination register of a dispatched instruction
    logic  rename_wr_en;
    reg_t  rename_rdest;
    tag_t  rename_tag;

    // Commit of the instruction at the ROB head
    logic  retire_wr_en;
    reg_t  retire_rdest;
    data_t retire_data;
    tag_t  retire_tag;

    // Source operand lookup for the instruction being dispatched
    reg_t  lookup_rsrc [0:SRC_COUNT-1];
    logic  lookup_rdy  [0:SRC_COUNT-1];
    tag_t  lookup_tag  [0:SRC_COUNT-1];
    data_t lookup_data [0:SRC_COUNT-1];

    // Flush of all speculative renames
    logic  redirect;

    modport rob (
        output rename_wr_en, rename_rdest, rename_tag,
        output retire_wr_en, retire_rdest, retire_data, retire_tag,
        output lookup_rsrc, redirect,
        input  lookup_rdy, lookup_tag, lookup_data
    );

    modport map (
        input  rename_wr_en, rename_rdest, rename_tag,
        input  retire_wr_en, retire_rdest, retire_data, retire_tag,
        input  lookup_rsrc, redirect,
        output lookup_rdy, lookup_tag, lookup_data
    );

endinterface

`default_nettype wire

// ==== design/reorder_buffer.sv ====
/*
 * Reorder buffer
 * Allocates entries at dispatch, collects CDB results, forwards source
 * operands and retires the head in program order, flushing on redirect
 */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer import core_cfg_pkg::*, core_types_pkg::*; (
    input  wire logic    clk,
    input  wire logic    n_rst,

    cdb_if.snk           cdb,
    regmap_if.rob        regmap,

    // Dispatcher side
    input  wire logic    i_rob_en,
    input  wire logic    i_rob_rdy,
    input  rob_op_t      i_rob_op,
    input  addr_t        i_rob_iaddr,
    input  addr_t        i_rob_addr,
    input  data_t        i_rob_data,
    input  reg_t         i_rob_rdest,
    input  reg_t         i_rob_rsrc     [0:SRC_COUNT-1],
    output tag_t         o_rob_tag,
    output data_t        o_rob_src_data [0:SRC_COUNT-1],
    output tag_t         o_rob_src_tag  [0:SRC_COUNT-1],
    output logic         o_rob_src_rdy  [0:SRC_COUNT-1],
    output logic         o_rob_stall,

    // Load/store unit side
    input  wire logic    i_lsu_retire_launched,
    input  wire logic    i_lsu_retire_misspeculated,
    output logic         o_lsu_retire_lq_en,
    output logic         o_lsu_retire_sq_en,
    output tag_t         o_lsu_retire_tag,

    // Fetch redirect and commit
    output logic         o_redirect,
    output addr_t        o_redirect_addr,
    output logic         o_retire_en,
    output reg_t         o_retire_rdest,
    output data_t        o_retire_data
);

    // Entry payload, the ready bits live beside it in rob_rdy
    typedef struct packed {
        logic    redirect;
        rob_op_t op;
        addr_t   iaddr;
        addr_t   addr;
        data_t   data;
        reg_t    rdest;
    } rob_entry_t;

    rob_entry_t           rob_entries [0:ROB_DEPTH-1];
    logic [ROB_DEPTH-1:0] rob_rdy;
    tagp_t                rob_head;
    tagp_t                rob_tail;
    tag_t                 head_addr;
    tag_t                 tail_addr;
    logic                 rob_full;
    logic                 rob_empty;
    logic                 dispatch_en;
    logic                 head_is_load;
    logic                 head_is_store;
    logic                 load_stall;
    logic                 retire_en;
    logic                 redirect;

    assign head_addr = rob_head[TAG_WIDTH-1:0];
    assign tail_addr = rob_tail[TAG_WIDTH-1:0];

    // Same index with opposite wrap bits means every entry is taken
    assign rob_full  = ({~rob_tail[TAG_WIDTH], tail_addr} == rob_head);
    assign rob_empty = (rob_tail == rob_head);

    // A full buffer drops the dispatch request
    assign dispatch_en = i_rob_en && !rob_full;

    assign head_is_load  = (rob_entries[head_addr].op == ROB_OP_LD);
    assign head_is_store = (rob_entries[head_addr].op == ROB_OP_ST);

    // A load still in flight in the LSU holds the head
    assign load_stall = head_is_load && i_lsu_retire_launched;
    assign retire_en  = rob_rdy[head_addr] && !rob_empty && !load_stall;

    // Flagged entries and misspeculated loads restart fetch
    assign redirect = retire_en &&
                      (rob_entries[head_addr].redirect ||
                       (head_is_load && i_lsu_retire_misspeculated));

    assign o_redirect = redirect;
    // Branches go to their resolved target, everything else replays from its own address
    assign o_redirect_addr = (rob_entries[head_addr].op == ROB_OP_BR) ?
                             rob_entries[head_addr].addr : rob_entries[head_addr].iaddr;

    assign o_retire_en    = retire_en;
    assign o_retire_rdest = rob_entries[head_addr].rdest;
    assign o_retire_data  = rob_entries[head_addr].data;

    assign o_lsu_retire_lq_en = retire_en && head_is_load;
    assign o_lsu_retire_sq_en = retire_en && head_is_store;
    assign o_lsu_retire_tag   = head_addr;

    assign o_rob_tag   = tail_addr;
    assign o_rob_stall = rob_full;

    // Register map updates
    assign regmap.rename_wr_en = dispatch_en;
    assign regmap.rename_rdest = i_rob_rdest;
    assign regmap.rename_tag   = tail_addr;
    assign regmap.retire_wr_en = retire_en;
    assign regmap.retire_rdest = rob_entries[head_addr].rdest;
    assign regmap.retire_data  = rob_entries[head_addr].data;
    assign regmap.retire_tag   = head_addr;
    assign regmap.redirect     = redirect;
    assign regmap.lookup_rsrc  = i_rob_rsrc;

    // Source operands come from the map when committed data is ready
    // Otherwise a same-cycle CDB result for the producer wins over the
    // producer's ROB entry, which may or may not have completed yet
    always_comb begin
        for (int i = 0; i < SRC_COUNT; i++) begin
            o_rob_src_tag[i] = regmap.lookup_tag[i];
            if (regmap.lookup_rdy[i]) begin
                o_rob_src_data[i] = regmap.lookup_data[i];
                o_rob_src_rdy[i]  = 1'b1;
            end else begin
                o_rob_src_data[i] = rob_entries[regmap.lookup_tag[i]].data;
                o_rob_src_rdy[i]  = rob_rdy[regmap.lookup_tag[i]];
                for (int j = 0; j < CDB_DEPTH; j++) begin
                    if (cdb.en[j] && (cdb.tag[j] == regmap.lookup_tag[i])) begin
                        o_rob_src_data[i] = cdb.data[j];
                        o_rob_src_rdy[i]  = 1'b1;
                    end
                end
            end
        end
    end

    // Entry payload, written at dispatch and again by the CDB at completion
    always_ff @(posedge clk) begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (dispatch_en && (tail_addr == tag_t'(i))) begin
                rob_entries[i] <= '{redirect: 1'b0, op: i_rob_op, iaddr: i_rob_iaddr,
                                    addr: i_rob_addr, data: i_rob_data, rdest: i_rob_rdest};
            end else begin
                for (int j = 0; j < CDB_DEPTH; j++) begin
                    if (cdb.en[j] && (cdb.tag[j] == tag_t'(i))) begin
                        rob_entries[i].redirect <= cdb.redirect[j];
                        rob_entries[i].addr     <= cdb.addr[j];
                        rob_entries[i].data     <= cdb.data[j];
                    end
                end
            end
        end
    end

    // Ready bits, cleared on flush so stale entries never look complete
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            rob_rdy <= '0;
        end else if (redirect) begin
            rob_rdy <= '0;
        end else begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                if (dispatch_en && (tail_addr == tag_t'(i))) begin
                    rob_rdy[i] <= i_rob_rdy;
                end else begin
                    for (int j = 0; j < CDB_DEPTH; j++) begin
                        if (cdb.en[j] && (cdb.tag[j] == tag_t'(i))) begin
                            rob_rdy[i] <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    // Pointers restart at entry 0 after a redirect
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            rob_head <= '0;
            rob_tail <= '0;
        end else if (redirect) begin
            rob_head <= '0;
            rob_tail <= '0;
        end else begin
            if (dispatch_en) begin
                rob_tail <= rob_tail + 1'b1;
            end
            if (retire_en) begin
                rob_head <= rob_head + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/rob_core.sv ====
/*
 * Commit stage top level
 * Joins the reorder buffer and the register map behind plain ports
 */
`timescale 1ns/1ps
`default_nettype none

module rob_core import core_cfg_pkg::*, core_types_pkg::*; (
    input  wire logic    clk,
    input  wire logic    n_rst,

    // CDB lanes from the execution units
    input  wire logic    i_cdb_en       [0:CDB_DEPTH-1],
    input  wire logic    i_cdb_redirect [0:CDB_DEPTH-1],
    input  data_t        i_cdb_data     [0:CDB_DEPTH-1],
    input  addr_t        i_cdb_addr     [0:CDB_DEPTH-1],
    input  tag_t         i_cdb_tag      [0:CDB_DEPTH-1],

    // Dispatcher
    input  wire logic    i_rob_en,
    input  wire logic    i_rob_rdy,
    input  rob_op_t      i_rob_op,
    input  addr_t        i_rob_iaddr,
    input  addr_t        i_rob_addr,
    input  data_t        i_rob_data,
    input  reg_t         i_rob_rdest,
    input  reg_t         i_rob_rsrc     [0:SRC_COUNT-1],
    output tag_t         o_rob_tag,
    output data_t        o_rob_src_data [0:SRC_COUNT-1],
    output tag_t         o_rob_src_tag  [0:SRC_COUNT-1],
    output logic         o_rob_src_rdy  [0:SRC_COUNT-1],
    output logic         o_rob_stall,

    // Load/store unit
    input  wire logic    i_lsu_retire_launched,
    input  wire logic    i_lsu_retire_misspeculated,
    output logic         o_lsu_retire_lq_en,
    output logic         o_lsu_retire_sq_en,
    output tag_t         o_lsu_retire_tag,

    // Fetch redirect and commit
    output logic         o_redirect,
    output addr_t        o_redirect_addr,
    output logic         o_retire_en,
    output reg_t         o_retire_rdest,
    output data_t        o_retire_data
);

    cdb_if    cdb_bus ();
    regmap_if regmap_bus ();

    // The execution units sit outside, so their lanes enter here
    assign cdb_bus.en       = i_cdb_en;
    assign cdb_bus.redirect = i_cdb_redirect;
    assign cdb_bus.data     = i_cdb_data;
    assign cdb_bus.addr     = i_cdb_addr;
    assign cdb_bus.tag      = i_cdb_tag;

    reorder_buffer reorder_buffer_inst (
        .clk                        (clk),
        .n_rst                      (n_rst),
        .cdb                        (cdb_bus.snk),
        .regmap                     (regmap_bus.rob),
        .i_rob_en                   (i_rob_en),
        .i_rob_rdy                  (i_rob_rdy),
        .i_rob_op                   (i_rob_op),
        .i_rob_iaddr                (i_rob_iaddr),
        .i_rob_addr                 (i_rob_addr),
        .i_rob_data                 (i_rob_data),
        .i_rob_rdest                (i_rob_rdest),
        .i_rob_rsrc                 (i_rob_rsrc),
        .o_rob_tag                  (o_rob_tag),
        .o_rob_src_data             (o_rob_src_data),
        .o_rob_src_tag              (o_rob_src_tag),
        .o_rob_src_rdy              (o_rob_src_rdy),
        .o_rob_stall                (o_rob_stall),
        .i_lsu_retire_launched      (i_lsu_retire_launched),
        .i_lsu_retire_misspeculated (i_lsu_retire_misspeculated),
        .o_lsu_retire_lq_en         (o_lsu_retire_lq_en),
        .o_lsu_retire_sq_en         (o_lsu_retire_sq_en),
        .o_lsu_retire_tag           (o_lsu_retire_tag),
        .o_redirect                 (o_redirect),
        .o_redirect_addr            (o_redirect_addr),
        .o_retire_en                (o_retire_en),
        .o_retire_rdest             (o_retire_rdest),
        .o_retire_data              (o_retire_data)
    );

    register_map register_map_inst (
        .clk    (clk),
        .n_rst  (n_rst),
        .regmap (regmap_bus.map)
    );

endmodule

`default_nettype wire

// ==== dv/rob_core_asserts.sv ====
/*
 * Reorder buffer assertions
 * Stall, redirect, LSU enable and tag sanity checked at every clock edge
 */
`timescale 1ns/1ps
`default_nettype none

module rob_core_asserts import core_cfg_pkg::*, core_types_pkg::*; (
    input  wire logic clk,
    input  wire logic n_rst,
    input  wire logic i_rob_stall,
    input  wire logic i_redirect,
    input  wire logic i_retire_en,
    input  wire logic i_lq_en,
    input  wire logic i_sq_en,
    input  tag_t      i_rob_tag,
    input  tag_t      i_lsu_tag
);

    // A full buffer allocates nothing, so the tail that names the rename stays put
    // Only a redirect may move the tail during a stall
    stall_blocks_rename: assert property (@(posedge clk) disable iff (!n_rst)
        i_rob_stall && !i_redirect |=> (i_rob_tag == $past(i_rob_tag)))
        else $error("tail advanced while the ROB was full");

    // Only the retiring head restarts fetch
    // One cycle later the buffer is empty and the tail is back at entry 0
    redirect_needs_retire: assert property (@(posedge clk) disable iff (!n_rst)
        $past(i_redirect) |-> $past(i_retire_en) && !i_retire_en && (i_rob_tag == '0))
        else $error("redirect raised without a retire or without a flush");

    // The head is never a load and a store at once
    // Unless it redirects, a load or store retire moves the head on by one
    lsu_enables_exclusive: assert property (@(posedge clk) disable iff (!n_rst)
        (i_lq_en || i_sq_en) |=>
            !$past(i_lq_en && i_sq_en) &&
            ($past(i_redirect) || (i_lsu_tag == tag_t'($past(i_lsu_tag) + 1'b1))))
        else $error("LSU retire enables clashed or the head did not advance");

    tag_known: assert property (@(posedge clk) disable iff (!n_rst)
        !$isunknown(i_rob_tag))
        else $error("dispatch tag is unknown");

endmodule

`default_nettype wire

// ==== dv/rob_core_tb.sv ====
/*
 * Commit stage testbench
 * Plays a command file against rob_core and checks every response
 */
`timescale 1ns/1ps
`default_nettype none

module rob_core_tb import core_cfg_pkg::*, core_types_pkg::*; ();

    logic    clk;
    logic    n_rst;
    logic    i_cdb_en       [0:CDB_DEPTH-1];
    logic    i_cdb_redirect [0:CDB_DEPTH-1];
    data_t   i_cdb_data     [0:CDB_DEPTH-1];
    addr_t   i_cdb_addr     [0:CDB_DEPTH-1];
    tag_t    i_cdb_tag      [0:CDB_DEPTH-1];
    logic    i_rob_en;
    logic    i_rob_rdy;
    rob_op_t i_rob_op;
    addr_t   i_rob_iaddr;
    addr_t   i_rob_addr;
    data_t   i_rob_data;
    reg_t    i_rob_rdest;
    reg_t    i_rob_rsrc     [0:SRC_COUNT-1];
    tag_t    o_rob_tag;
    data_t   o_rob_src_data [0:SRC_COUNT-1];
    tag_t    o_rob_src_tag  [0:SRC_COUNT-1];
    logic    o_rob_src_rdy  [0:SRC_COUNT-1];
    logic    o_rob_stall;
    logic    i_lsu_retire_launched;
    logic    i_lsu_retire_misspeculated;
    logic    o_lsu_retire_lq_en;
    logic    o_lsu_retire_sq_en;
    tag_t    o_lsu_retire_tag;
    logic    o_redirect;
    addr_t   o_redirect_addr;
    logic    o_retire_en;
    reg_t    o_retire_rdest;
    data_t   o_retire_data;

    int          errors = 0;
    int          checks = 0;
    int          test_errors = 0;
    int          test_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    logic        settled;
    logic [31:0] rng_state = 32'h27768888;
    logic [31:0] fld [0:9];
    data_t       rand_data [0:ROB_DEPTH-1];
    string       test_name = "";

    rob_core rob_core_inst (.*);

    bind reorder_buffer rob_core_asserts rob_core_asserts_inst (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_rob_stall (o_rob_stall),
        .i_redirect  (o_redirect),
        .i_retire_en (o_retire_en),
        .i_lq_en     (o_lsu_retire_lq_en),
        .i_sq_en     (o_lsu_retire_sq_en),
        .i_rob_tag   (o_rob_tag),
        .i_lsu_tag   (o_lsu_retire_tag)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Hard stop in case the DUT or the command file never lets the run end
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the stimulus did not finish", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic note_fail();
        errors++;
        test_errors++;
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        checks++;
        if (act !== exp) begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            note_fail();
        end
    endtask

    task automatic check_tag(input string name, input tag_t exp, input tag_t act);
        checks++;
        if (act !== exp) begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            note_fail();
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        checks++;
        if (act !== exp) begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            note_fail();
        end
    endtask

    task automatic check_reg(input string name, input reg_t exp, input reg_t act);
        checks++;
        if (act !== exp) begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            note_fail();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            note_fail();
        end
    endtask

    // Every cycle starts from the idle values
    task automatic clear_inputs();
        for (int j = 0; j < CDB_DEPTH; j++) begin
            i_cdb_en[j]       = 1'b0;
            i_cdb_redirect[j] = 1'b0;
            i_cdb_data[j]     = '0;
            i_cdb_addr[j]     = '0;
            i_cdb_tag[j]      = '0;
        end
        for (int i = 0; i < SRC_COUNT; i++) begin
            i_rob_rsrc[i] = '0;
        end
        i_rob_en                   = 1'b0;
        i_rob_rdy                  = 1'b0;
        i_rob_op                   = ROB_OP_INT;
        i_rob_iaddr                = '0;
        i_rob_addr                 = '0;
        i_rob_data                 = '0;
        i_rob_rdest                = '0;
        i_lsu_retire_launched      = 1'b0;
        i_lsu_retire_misspeculated = 1'b0;
    endtask

    // Inputs change on the falling edge, so the DUT sees them stable at the rising one
    task automatic advance(input int n);
        repeat (n) begin
            @(negedge clk);
            clear_inputs();
            settled = 1'b0;
        end
    endtask

    // Combinational outputs are sampled 1 ns after the last drive
    task automatic settle();
        if (!settled) begin
            #1;
            settled = 1'b1;
        end
    endtask

    task automatic close_test();
        if (test_name != "") begin
            $display("Test %s finished with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic expect_retire(input reg_t rdest, input data_t data);
        settle();
        check_bit("o_retire_en", 1'b1, o_retire_en);
        check_reg("o_retire_rdest", rdest, o_retire_rdest);
        check_data("o_retire_data", data, o_retire_data);
    endtask

    // Runs one command from the stimulus file
    // Field 0 holds the number of cycles to advance first
    task automatic run_command(input string cmd);
        logic lane;
        logic idx;
        tag_t tag;
        lane = fld[1][0];
        idx  = fld[1][0];
        tag  = fld[2][TAG_WIDTH-1:0];
        advance(int'(fld[0]));
        case (cmd)
            "D": begin
                i_rob_en      = 1'b1;
                i_rob_op      = rob_op_t'(fld[1][1:0]);
                i_rob_rdest   = fld[2][REG_WIDTH-1:0];
                i_rob_rsrc[0] = fld[3][REG_WIDTH-1:0];
                i_rob_rsrc[1] = fld[4][REG_WIDTH-1:0];
                i_rob_iaddr   = fld[5];
                i_rob_addr    = fld[6];
                i_rob_data    = fld[7];
                i_rob_rdy     = fld[8][0];
                settled       = 1'b0;
                settle();
                check_tag("o_rob_tag", fld[9][TAG_WIDTH-1:0], o_rob_tag);
            end
            "C": begin
                i_cdb_en[lane]       = 1'b1;
                i_cdb_tag[lane]      = tag;
                i_cdb_data[lane]     = fld[3];
                i_cdb_redirect[lane] = fld[4][0];
                i_cdb_addr[lane]     = fld[5];
                settled              = 1'b0;
            end
            "Q": begin
                // The random result is remembered per tag for the retire check
                rng_state        = xorshift32(rng_state);
                rand_data[tag]   = rng_state;
                i_cdb_en[lane]   = 1'b1;
                i_cdb_tag[lane]  = tag;
                i_cdb_data[lane] = rng_state;
                settled          = 1'b0;
            end
            "L": begin
                i_lsu_retire_launched      = fld[1][0];
                i_lsu_retire_misspeculated = fld[2][0];
                settled                    = 1'b0;
            end
            "A": begin
                i_rob_rsrc[0] = fld[1][REG_WIDTH-1:0];
                i_rob_rsrc[1] = fld[2][REG_WIDTH-1:0];
                settled       = 1'b0;
            end
            "E": expect_retire(fld[1][REG_WIDTH-1:0], fld[2]);
            "F": expect_retire(fld[2][REG_WIDTH-1:0], rand_data[fld[1][TAG_WIDTH-1:0]]);
            "O": begin
                settle();
                check_bit($sformatf("o_rob_src_rdy[%0d]", idx), fld[2][0], o_rob_src_rdy[idx]);
                if (fld[2][0]) begin
                    check_data($sformatf("o_rob_src_data[%0d]", idx), fld[3],
                               o_rob_src_data[idx]);
                end else begin
                    check_tag($sformatf("o_rob_src_tag[%0d]", idx), fld[3][TAG_WIDTH-1:0],
                              o_rob_src_tag[idx]);
                end
            end
            "R": begin
                settle();
                check_bit("o_retire_en", 1'b1, o_retire_en);
                check_bit("o_redirect", 1'b1, o_redirect);
                check_addr("o_redirect_addr", fld[1], o_redirect_addr);
            end
            "Z": begin
                settle();
                check_bit("o_retire_en", 1'b0, o_retire_en);
                check_bit("o_redirect", 1'b0, o_redirect);
            end
            "M": begin
                settle();
                check_bit("o_lsu_retire_lq_en", fld[1][0], o_lsu_retire_lq_en);
                check_bit("o_lsu_retire_sq_en", fld[2][0], o_lsu_retire_sq_en);
                check_tag("o_lsu_retire_tag", fld[3][TAG_WIDTH-1:0], o_lsu_retire_tag);
            end
            "S": begin
                settle();
                check_bit("o_rob_stall", fld[1][0], o_rob_stall);
            end
            default: begin
                $display("Unknown command %s in the stimulus file", cmd);
                note_fail();
            end
        endcase
    endtask

    initial begin
        int    fd;
        int    lines;
        int    n;
        string line;
        string cmd;
        string name;
        clear_inputs();
        n_rst   = 1'b0;
        settled = 1'b0;
        lines   = 0;
        // First pass only counts lines to size the timeout
        fd = $fopen("dv/rob_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file dv/rob_stimulus.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                lines++;
            end
            $fclose(fd);
        end
        cycle_limit = 4 * lines + 100;
        repeat (8) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;
        if (errors == 0) begin
            fd = $fopen("dv/rob_stimulus.txt", "r");
            while ($fgets(line, fd) > 0) begin
                cmd = "";
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", cmd, fld[0], fld[1],
                            fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8], fld[9]);
                if (cmd == "" || cmd.getc(0) == "#") begin
                    continue;
                end
                if (cmd == "T") begin
                    n = $sscanf(line, "%s %s", cmd, name);
                    close_test();
                    test_name   = name;
                    test_errors = 0;
                    test_count++;
                end else begin
                    run_command(cmd);
                end
            end
            $fclose(fd);
            close_test();
        end
        $display("%0d tests, %0d checks, %0d errors", test_count, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/rob_stimulus.txt ====
# cmd adv fields, all hex, adv = cycles to step before the command
# T name | D op rdest rs0 rs1 iaddr addr data rdy tag | C lane tag data redir addr | Q lane tag
# L launched missp | A rs0 rs1 | E rdest data | F tag rdest | O idx rdy data_or_tag
# R addr | Z | M lq sq tag | S stall
T in_order_retire
D 0 0 01 00 00 100 0 0 0 0
D 1 0 02 00 00 104 0 0 0 1
D 1 0 03 00 00 108 0 0 0 2
D 1 0 04 00 00 10c 0 0 0 3
C 1 0 3 33 0 0
C 0 1 2 22 0 0
Z 0
Q 1 0 1
Z 0
C 1 0 0 11 0 0
Z 0
E 1 01 11
F 1 1 02
E 1 03 22
E 1 04 33
A 1 01 04
O 0 0 1 11
O 0 1 1 33
T full_and_stall
D 1 0 05 00 00 200 0 0 0 4
D 1 0 05 00 00 200 0 0 0 5
D 1 0 05 00 00 200 0 0 0 6
D 1 0 05 00 00 200 0 0 0 7
D 1 0 05 00 00 200 0 0 0 0
D 1 0 05 00 00 200 0 0 0 1
D 1 0 05 00 00 200 0 0 0 2
D 1 0 05 00 00 200 0 0 0 3
S 1 1
D 0 0 05 00 00 200 0 0 0 4
C 1 0 4 44 0 0
E 1 05 44
S 0 1
S 1 0
D 0 0 05 00 00 200 0 0 0 4
C 1 0 5 0 1 0
R 1 200
T operand_select
D 1 0 06 01 00 300 0 0 0 0
O 0 0 1 11
D 1 0 07 00 00 304 0 0 0 1
C 1 0 0 66 0 0
D 0 0 08 06 07 308 0 0 0 2
O 0 0 1 66
O 0 1 0 1
E 1 06 66
C 0 1 1 77 0 0
E 1 07 77
D 0 0 00 07 08 30c 0 0 0 3
O 0 0 1 77
O 0 1 0 2
T branch_redirect
D 1 1 00 00 00 400 0 0 0 4
C 0 0 2 88 0 0
C 0 1 3 0 0 0
E 1 08 88
C 0 0 4 0 1 480
D 0 0 09 00 00 404 0 0 0 5
E 1 00 0
R 1 480
Z 1
A 0 08 09
O 0 0 1 88
O 0 1 1 0
T load_store_retire
D 1 3 00 00 00 500 0 0 1 0
D 1 2 0a 00 00 600 0 5a 1 1
M 0 0 1 0
L 1 1 0
M 0 0 0 1
Z 0
L 1 0 0
M 0 1 0 1
E 0 0a 5a
D 0 2 0b 00 00 700 0 0 1 2
L 1 0 1
R 0 700
M 0 1 0 2
D 1 0 0c 00 00 800 0 0 0 0
S 0 0

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the commit stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module rob_core_tb -o rob_core_sim > build.log 2>&1 &&
./obj_dir/rob_core_sim > sim.log 2>&1 ||
{ echo "Build or simulation aborted, see build.log and sim.log"; exit 1; }
grep -q "Errors found" sim.log &&
{ echo "Simulation reported failures, see sim.log"; exit 1; } ||
{ echo "Simulation passed"; exit 0; }

// ==== sim.f ====
design/core_cfg_pkg.sv
design/core_types_pkg.sv
design/cdb_if.sv
design/regmap_if.sv
design/reorder_buffer.sv
design/register_map.sv
design/rob_core.sv
dv/rob_core_asserts.sv
dv/rob_core_tb.sv
